// ==== Makefile ====
# Verilator flow for the pipeline-control testbench
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= pipeCtrlTb
RTL_TOP ?= pipeCtrlTop
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
PASS_MSG ?= Simulation finished: PASS

.PHONY: all lint lint-rtl build sim clean

all: sim

# lint the testbench together with the design
lint: lint-rtl
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# lint the design on its own
lint-rtl:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+include
rtl/pipeCtrlPkg.sv
rtl/hazardUnit.sv
rtl/fetchSeq.sv
rtl/stageChain.sv
rtl/pipeCtrlTop.sv
test/pipeCtrlTb.sv

// ==== include/pipeAssert.svh ====
`ifndef PIPE_ASSERT_SVH
`define PIPE_ASSERT_SVH

// plain invariant checked every clk once out of reset
`define pipeAssert(name, prop, msg) \
    name: assert property (@(posedge clk) disable iff (!rstN) (prop)) else $error(msg);

// same-cycle implication
`define pipeAssertImp(name, ante, cons, msg) \
    name: assert property (@(posedge clk) disable iff (!rstN) (ante) |-> (cons)) else $error(msg);

// consequence checked one cycle after the antecedent
`define pipeAssertNext(name, ante, cons, msg) \
    name: assert property (@(posedge clk) disable iff (!rstN) (ante) |=> (cons)) else $error(msg);

`endif

// ==== rtl/fetchSeq.sv ====
`include "pipeAssert.svh"

module fetchSeq (
    input logic clk,
    input logic rstN,
    input pipeCtrlPkg::stageCtrlT ctrl,
    input pipeCtrlPkg::pcT branchTarget,
    input pipeCtrlPkg::pcT misalignTarget,
    output pipeCtrlPkg::pcT fetchPc
);

    // F register
    pipeCtrlPkg::pcT pcQ;
    // target parked while F is stalled
    pipeCtrlPkg::pcT heldPc;
    logic heldValid;
    // target picked by the hazard unit's select
    pipeCtrlPkg::pcT redirTarget;
    logic redirNow;

    assign redirNow = ctrl.redirSel != pipeCtrlPkg::redirNone;

    always_comb begin
        case (ctrl.redirSel)
            pipeCtrlPkg::redirExcp: redirTarget = pipeCtrlPkg::excVector;
            pipeCtrlPkg::redirBranch: redirTarget = branchTarget;
            pipeCtrlPkg::redirMisalign: redirTarget = misalignTarget;
            // unused without a redirect
            default: redirTarget = heldPc;
        endcase
    end

    // PC and held-valid
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcQ <= pipeCtrlPkg::resetPc;
            heldValid <= 1'b0;
        end else if (ctrl.stallF) begin
            // fetch busy so remember that a target is waiting
            if (redirNow) begin
                heldValid <= 1'b1;
            end
        end else begin
            // fresh redirect beats an older parked one
            if (redirNow) begin
                pcQ <= redirTarget;
            end else if (heldValid) begin
                pcQ <= heldPc;
            end else begin
                pcQ <= pcQ + pipeCtrlPkg::pcStep;
            end
            heldValid <= 1'b0;
        end
    end

    // latest target is meaningful only with heldValid
    always_ff @(posedge clk) begin
        if (redirNow) begin
            heldPc <= redirTarget;
        end
    end

    assign fetchPc = pcQ;

    `pipeAssert(aPcAligned, pcQ[1:0] == 2'b00, "fetch PC not word aligned")

endmodule

// ==== rtl/hazardUnit.sv ====
`include "pipeAssert.svh"

module hazardUnit (
    input logic clk,
    input logic rstN,
    // level waits from icache, dcache and a multicycle E unit
    input logic iWait,
    input logic dWait,
    input logic eWait,
    // redirect events
    input logic branchE,
    input logic branchMisalign,
    input logic excpW,
    output pipeCtrlPkg::stageCtrlT ctrl
);

    // redirects seen while a fetch was outstanding
    logic excpPend;
    logic branchPend;
    logic misalignPend;
    logic excpPendNext;
    logic branchPendNext;
    logic misalignPendNext;
    logic anyPend;

    assign anyPend = excpPend | branchPend | misalignPend;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            excpPend <= 1'b0;
            branchPend <= 1'b0;
            misalignPend <= 1'b0;
        end else begin
            excpPend <= excpPendNext;
            branchPend <= branchPendNext;
            misalignPend <= misalignPendNext;
        end
    end

    always_comb begin
        ctrl = '0;
        ctrl.redirSel = pipeCtrlPkg::redirNone;
        excpPendNext = excpPend;
        branchPendNext = branchPend;
        misalignPendNext = misalignPend;

        if (excpW) begin
            // trap from W kills every slot including W
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.flushI = 1'b1;
            ctrl.flushE = 1'b1;
            ctrl.flushM = 1'b1;
            ctrl.flushW = 1'b1;
            ctrl.redirSel = pipeCtrlPkg::redirExcp;
            // fetch still busy so the PC cannot move yet
            if (iWait) begin
                ctrl.stallF = 1'b1;
                excpPendNext = 1'b1;
            end
        end else if (eWait) begin
            // freeze up to E
            ctrl.stallF = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
            ctrl.stallE = 1'b1;
            // M holds too if the dcache is busy and takes a bubble otherwise
            if (dWait) begin
                ctrl.stallM = 1'b1;
            end else begin
                ctrl.flushM = 1'b1;
            end
        end else if (dWait) begin
            ctrl.stallF = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
            ctrl.stallE = 1'b1;
            ctrl.stallM = 1'b1;
        end else if (iWait) begin
            // no instruction yet so F2 gets bubbles
            ctrl.stallF = 1'b1;
            ctrl.flushF2 = 1'b1;
            // older event wins since a branch at E squashes the misaligned D
            if (branchE) begin
                ctrl.flushD = 1'b1;
                ctrl.flushI = 1'b1;
                ctrl.flushE = 1'b1;
                ctrl.flushM = 1'b1;
                ctrl.redirSel = pipeCtrlPkg::redirBranch;
                branchPendNext = 1'b1;
            end else if (branchMisalign) begin
                ctrl.flushD = 1'b1;
                ctrl.redirSel = pipeCtrlPkg::redirMisalign;
                misalignPendNext = 1'b1;
            end
        end else if (branchE) begin
            // E and everything younger goes
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.flushI = 1'b1;
            ctrl.flushE = 1'b1;
            ctrl.flushM = 1'b1;
            ctrl.redirSel = pipeCtrlPkg::redirBranch;
        end else if (branchMisalign) begin
            // D survives and only F and F2 contents drop
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.redirSel = pipeCtrlPkg::redirMisalign;
        end

        // fetch done after a redirect leaves a stale word in F
        // wait for F to actually move so the flush lines up with the PC load
        if (!iWait && anyPend && !ctrl.stallF) begin
            ctrl.flushF2 = 1'b1;
            excpPendNext = 1'b0;
            branchPendNext = 1'b0;
            misalignPendNext = 1'b0;
        end
    end

    `pipeAssertImp(aExcpFlushAll, excpW,
        &{ctrl.flushF2, ctrl.flushD, ctrl.flushI, ctrl.flushE, ctrl.flushM, ctrl.flushW},
        "exception did not flush every slot")

    `pipeAssert(aStallFlushM, !(ctrl.stallM && ctrl.flushM),
        "M stalled and flushed in the same cycle")

    `pipeAssertImp(aQuietNoRedir, !(branchE || branchMisalign || excpW),
        ctrl.redirSel == pipeCtrlPkg::redirNone, "redirect without an event")

endmodule

// ==== rtl/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

    // instruction address as seen by fetch and every stage slot
    typedef logic [31:0] pcT;

    // first fetch address once rstN goes high
    localparam pcT resetPc = 32'h0000_1000;
    // trap handler entry loaded when W raises an exception
    localparam pcT excVector = 32'h0000_0100;
    // sequential fetch step of one word
    localparam pcT pcStep = 32'd4;

    // slots F2 through W carried by the stage chain
    localparam int numSlots = 7;
    localparam int slotF2 = 0;
    localparam int slotD = 1;
    localparam int slotI = 2;
    localparam int slotE = 3;
    localparam int slotM = 4;
    localparam int slotM2 = 5;
    localparam int slotW = 6;

    // which target the fetch sequencer should take
    typedef enum logic [1:0] {
        redirNone = 2'd0,
        redirExcp = 2'd1,
        redirBranch = 2'd2,
        redirMisalign = 2'd3
    } redirSelT;

    // per-cycle strobes from the hazard unit
    // M2 and W never stall and have no stall bits
    typedef struct packed {
        logic stallF;
        logic stallF2;
        logic stallD;
        logic stallI;
        logic stallE;
        logic stallM;
        logic flushF2;
        logic flushD;
        logic flushI;
        logic flushE;
        logic flushM;
        logic flushW;
        redirSelT redirSel;
    } stageCtrlT;

    // one stage's contents
    // valid low marks a bubble
    typedef struct packed {
        logic valid;
        pcT pc;
    } slotT;

    // slots the surrounding datapath looks at
    typedef struct packed {
        slotT d;
        slotT e;
        slotT w;
    } pipeViewT;

endpackage

// ==== rtl/pipeCtrlTop.sv ====
module pipeCtrlTop (
    input logic clk,
    input logic rstN,
    // back-pressure from the memories and E
    input logic iWait,
    input logic dWait,
    input logic eWait,
    // redirect events and their targets
    input logic branchE,
    input logic branchMisalign,
    input logic excpW,
    input pipeCtrlPkg::pcT branchTarget,
    input pipeCtrlPkg::pcT misalignTarget,
    // strobes for the datapath
    output pipeCtrlPkg::stageCtrlT ctrl,
    output pipeCtrlPkg::pipeViewT view,
    // instruction leaving W
    output logic retireValid,
    output pipeCtrlPkg::pcT retirePc
);

    // F register into F2
    pipeCtrlPkg::pcT fetchPc;

    // decides when to stall, flush and redirect
    hazardUnit uHazard (
        .clk(clk),
        .rstN(rstN),
        .iWait(iWait),
        .dWait(dWait),
        .eWait(eWait),
        .branchE(branchE),
        .branchMisalign(branchMisalign),
        .excpW(excpW),
        .ctrl(ctrl)
    );

    // decides where fetch goes
    fetchSeq uFetch (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .branchTarget(branchTarget),
        .misalignTarget(misalignTarget),
        .fetchPc(fetchPc)
    );

    // F2 through W
    stageChain uChain (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .fetchPc(fetchPc),
        .view(view),
        .retireValid(retireValid),
        .retirePc(retirePc)
    );

endmodule

// ==== rtl/stageChain.sv ====
`include "pipeAssert.svh"

module stageChain (
    input logic clk,
    input logic rstN,
    input pipeCtrlPkg::stageCtrlT ctrl,
    input pipeCtrlPkg::pcT fetchPc,
    output pipeCtrlPkg::pipeViewT view,
    output logic retireValid,
    output pipeCtrlPkg::pcT retirePc
);

    localparam int n = pipeCtrlPkg::numSlots;

    // index 0 is F2 and index n-1 is W
    logic [n-1:0] validQ;
    pipeCtrlPkg::pcT pcQ [n];
    pipeCtrlPkg::slotT slotNext [n];

    // per-slot control, same indexing
    logic [n-1:0] holdVec;
    logic [n-1:0] flushVec;
    // what the slot before each one does and offers
    logic [n-1:0] predHold;
    logic [n-1:0] predValid;
    pipeCtrlPkg::pcT predPc [n];

    // M2 and W never hold
    assign holdVec = {1'b0, 1'b0, ctrl.stallM, ctrl.stallE, ctrl.stallI,
                      ctrl.stallD, ctrl.stallF2};
    // M2 has no strobe of its own and goes down with W on a trap
    assign flushVec = {ctrl.flushW, ctrl.flushW, ctrl.flushM, ctrl.flushE,
                       ctrl.flushI, ctrl.flushD, ctrl.flushF2};

    // F always offers a live instruction
    assign predHold = {holdVec[n-2:0], ctrl.stallF};
    assign predValid = {validQ[n-2:0], 1'b1};

    always_comb begin
        predPc[0] = fetchPc;
        for (int i = 1; i < n; i++) begin
            predPc[i] = pcQ[i-1];
        end
    end

    always_comb begin
        for (int i = 0; i < n; i++) begin
            if (holdVec[i]) begin
                // hold
                slotNext[i].valid = validQ[i];
                slotNext[i].pc = pcQ[i];
            end else if (flushVec[i] || predHold[i]) begin
                // squash or bubble behind a held slot
                slotNext[i].valid = 1'b0;
                slotNext[i].pc = predPc[i];
            end else begin
                slotNext[i].valid = predValid[i];
                slotNext[i].pc = predPc[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= '0;
        end else begin
            for (int i = 0; i < n; i++) begin
                validQ[i] <= slotNext[i].valid;
            end
        end
    end

    // pc payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < n; i++) begin
            pcQ[i] <= slotNext[i].pc;
        end
    end

    assign view.d.valid = validQ[pipeCtrlPkg::slotD];
    assign view.d.pc = pcQ[pipeCtrlPkg::slotD];
    assign view.e.valid = validQ[pipeCtrlPkg::slotE];
    assign view.e.pc = pcQ[pipeCtrlPkg::slotE];
    assign view.w.valid = validQ[pipeCtrlPkg::slotW];
    assign view.w.pc = pcQ[pipeCtrlPkg::slotW];

    // faulting W instruction is dropped since flushW only comes with a trap
    assign retireValid = validQ[pipeCtrlPkg::slotW] & ~ctrl.flushW;
    assign retirePc = pcQ[pipeCtrlPkg::slotW];

    // held instruction must not also appear one slot further on
    for (genvar g = 0; g < n - 1; g++) begin : gHeldCheck
        `pipeAssertNext(aHeldNoDup, holdVec[g] && !holdVec[g+1] && validQ[g],
            !(validQ[g+1] && pcQ[g+1] == $past(pcQ[g])),
            "held slot duplicated into its successor")
    end

endmodule

// ==== test/pipeCtrlTb.sv ====
module pipeCtrlTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 100;
    // per-test cycle budgets whose sum sizes the watchdog
    localparam int lenStraight = 40;
    localparam int lenRandom = 200;
    localparam int lenBranch = 60;
    localparam int lenMisalign = 60;
    localparam int lenExcp = 60;
    localparam int lenFetchWait = 60;
    localparam int totalLen = lenStraight + lenRandom + lenBranch + lenMisalign
                              + lenExcp + lenFetchWait;

    logic clk;
    logic rstN;
    logic iWait;
    logic dWait;
    logic eWait;
    logic branchE;
    logic branchMisalign;
    logic excpW;
    pipeCtrlPkg::pcT branchTarget;
    pipeCtrlPkg::pcT misalignTarget;
    pipeCtrlPkg::stageCtrlT ctrl;
    pipeCtrlPkg::pipeViewT view;
    logic retireValid;
    pipeCtrlPkg::pcT retirePc;

    // expected retire order
    // genPc is the next sequential PC not yet queued
    pipeCtrlPkg::pcT expQ[$];
    pipeCtrlPkg::pcT genPc;
    pipeCtrlPkg::pcT lastRetirePc;
    int retireCount;
    int errCount;
    int checkTotal;
    int testsRun;
    int testsFailed;
    int errBefore;
    string curTest;
    logic [31:0] rngState;

    pipeCtrlTop DUT (
        .clk(clk),
        .rstN(rstN),
        .iWait(iWait),
        .dWait(dWait),
        .eWait(eWait),
        .branchE(branchE),
        .branchMisalign(branchMisalign),
        .excpW(excpW),
        .branchTarget(branchTarget),
        .misalignTarget(misalignTarget),
        .ctrl(ctrl),
        .view(view),
        .retireValid(retireValid),
        .retirePc(retirePc)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // xorshift32
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // advance to the drive point of the next cycle
    task automatic cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic checkPc(input string name, input pipeCtrlPkg::pcT exp,
                           input pipeCtrlPkg::pcT act);
        checkTotal++;
        if (exp !== act) begin
            $display("error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            errCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checkTotal++;
        if (exp !== act) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            errCount++;
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        checkTotal++;
        if (exp != act) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            errCount++;
        end
    endtask

    // next PC the model expects at W
    function automatic pipeCtrlPkg::pcT nextExpected();
        if (expQ.size() == 0) begin
            expQ.push_back(genPc);
            genPc = genPc + pipeCtrlPkg::pcStep;
        end
        return expQ.pop_front();
    endfunction

    // drop cut and everything younger and restart the stream at target
    task automatic truncateModel(input pipeCtrlPkg::pcT cut, input pipeCtrlPkg::pcT target);
        int idx;
        int guard;
        idx = -1;
        guard = 0;
        for (int i = 0; i < expQ.size(); i++) begin
            if (idx < 0 && expQ[i] == cut) idx = i;
        end
        // cut may lie beyond what has been queued so far
        while (idx < 0 && guard < 64) begin
            expQ.push_back(genPc);
            if (genPc == cut) idx = expQ.size() - 1;
            genPc = genPc + pipeCtrlPkg::pcStep;
            guard++;
        end
        if (idx < 0) begin
            $display("%s: redirect point 0x%08h is not in the expected stream", curTest, cut);
            errCount++;
        end else begin
            while (expQ.size() > idx) void'(expQ.pop_back());
        end
        genPc = target;
    endtask

    // retire monitor samples at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (rstN && retireValid) begin
            checkPc({curTest, " retire"}, nextExpected(), retirePc);
            lastRetirePc = retirePc;
            retireCount++;
        end
    end

    task automatic waitRetireCount(input int target, input int limit);
        int n;
        n = 0;
        while (retireCount < target && n < limit) begin
            cycle();
            n++;
        end
        if (retireCount < target) begin
            $display("%s: only %0d of %0d retires within %0d cycles", curTest,
                     retireCount, target, limit);
            errCount++;
        end
    endtask

    // wait for a valid slot
    // sel 0 picks D, 1 picks E and 2 picks W
    task automatic waitSlotValid(input int sel, input int limit);
        int n;
        n = 0;
        while (!(sel == 0 ? view.d.valid : sel == 1 ? view.e.valid : view.w.valid)
               && n < limit) begin
            cycle();
            n++;
        end
        if (n >= limit) begin
            $display("%s: pipeline slot never became valid", curTest);
            errCount++;
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        errBefore = errCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errCount == errBefore) begin
            $display("test %s: passed", curTest);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", curTest, errCount - errBefore);
        end
    endtask

    task automatic resetDut();
        rstN = 1'b0;
        repeat (2) cycle();
        rstN = 1'b1;
    endtask

    task automatic straightTest();
        int n;
        startTest("straight");
        checkBit("straight ctrl quiet after reset", 1'b0, |ctrl);
        checkBit("straight no retire after reset", 1'b0, retireValid);
        n = 0;
        while (!retireValid && n < 20) begin
            cycle();
            n++;
        end
        checkCount("straight cycles to first retire", 7, n);
        checkPc("straight first retire", pipeCtrlPkg::resetPc, retirePc);
        // one slot per cycle puts the 1st, 4th and 6th PCs in W, E and D
        checkBit("straight W valid", 1'b1, view.w.valid);
        checkPc("straight W pc", pipeCtrlPkg::resetPc, view.w.pc);
        checkBit("straight E valid", 1'b1, view.e.valid);
        checkPc("straight E pc",
                pipeCtrlPkg::resetPc + 32'd3 * pipeCtrlPkg::pcStep, view.e.pc);
        checkBit("straight D valid", 1'b1, view.d.valid);
        checkPc("straight D pc",
                pipeCtrlPkg::resetPc + 32'd5 * pipeCtrlPkg::pcStep, view.d.pc);
        waitRetireCount(20, lenStraight);
        checkPc("straight twentieth retire",
                pipeCtrlPkg::resetPc + 32'd19 * pipeCtrlPkg::pcStep, lastRetirePc);
        endTest();
    endtask

    task automatic randomWaitTest();
        logic [31:0] r;
        int startCount;
        startTest("randomWaits");
        startCount = retireCount;
        for (int c = 0; c < lenRandom; c++) begin
            r = nextRand();
            // roughly one iWait in four and one dWait or eWait in eight
            iWait = r[0] & r[1];
            dWait = r[2] & r[3] & r[4];
            eWait = r[5] & r[6] & r[7];
            cycle();
        end
        iWait = 1'b0;
        dWait = 1'b0;
        eWait = 1'b0;
        checkBit("randomWaits progress under waits", 1'b1, retireCount > startCount);
        // flow resumes once the waits drop
        waitRetireCount(retireCount + 8, 40);
        endTest();
    endtask

    task automatic branchTest();
        int base;
        startTest("branch");
        waitSlotValid(1, 20);
        branchTarget = 32'h0000_4000 + (nextRand() & 32'h0000_0ff0);
        branchE = 1'b1;
        truncateModel(view.e.pc, branchTarget);
        base = retireCount + expQ.size();
        #1;
        checkBit("branch flushes E", 1'b1, ctrl.flushE);
        cycle();
        branchE = 1'b0;
        waitRetireCount(base + 1, lenBranch / 2);
        checkPc("branch next retire", branchTarget, lastRetirePc);
        waitRetireCount(retireCount + 8, lenBranch / 2);
        endTest();
    endtask

    task automatic misalignTest();
        int base;
        startTest("misalign");
        waitSlotValid(0, 20);
        misalignTarget = 32'h0000_8000 + (nextRand() & 32'h0000_0ff0);
        branchMisalign = 1'b1;
        // D survives and its successor is the first casualty
        truncateModel(view.d.pc + pipeCtrlPkg::pcStep, misalignTarget);
        base = retireCount + expQ.size();
        #1;
        checkBit("misalign flushes D", 1'b1, ctrl.flushD);
        cycle();
        branchMisalign = 1'b0;
        waitRetireCount(base + 1, lenMisalign / 2);
        checkPc("misalign next retire", misalignTarget, lastRetirePc);
        waitRetireCount(retireCount + 8, lenMisalign / 2);
        endTest();
    endtask

    task automatic excpTest();
        int base;
        startTest("exception");
        waitSlotValid(2, 20);
        excpW = 1'b1;
        truncateModel(view.w.pc, pipeCtrlPkg::excVector);
        base = retireCount + expQ.size();
        #1;
        checkBit("exception faulting W retires", 1'b0, retireValid);
        cycle();
        excpW = 1'b0;
        // every slot took a bubble at the trap edge
        checkBit("exception D squashed", 1'b0, view.d.valid);
        checkBit("exception E squashed", 1'b0, view.e.valid);
        checkBit("exception W squashed", 1'b0, view.w.valid);
        waitRetireCount(base + 1, lenExcp / 2);
        checkPc("exception next retire", pipeCtrlPkg::excVector, lastRetirePc);
        waitRetireCount(retireCount + 8, lenExcp / 2);
        endTest();
    endtask

    task automatic fetchWaitBranchTest();
        int base;
        startTest("fetchWaitBranch");
        iWait = 1'b1;
        cycle();
        waitSlotValid(1, 10);
        branchTarget = 32'h0000_c000 + (nextRand() & 32'h0000_0ff0);
        branchE = 1'b1;
        truncateModel(view.e.pc, branchTarget);
        base = retireCount + expQ.size();
        cycle();
        branchE = 1'b0;
        // fetch stays busy a while after the redirect
        repeat (3) cycle();
        iWait = 1'b0;
        waitRetireCount(base + 1, lenFetchWait / 2);
        checkPc("fetchWaitBranch next retire", branchTarget, lastRetirePc);
        waitRetireCount(retireCount + 8, lenFetchWait / 2);
        endTest();
    endtask

    initial begin
        #(totalLen * 4 * clkPeriod);
        $display("timeout: run still going after %0d cycles", totalLen * 4);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        iWait = 1'b0;
        dWait = 1'b0;
        eWait = 1'b0;
        branchE = 1'b0;
        branchMisalign = 1'b0;
        excpW = 1'b0;
        branchTarget = '0;
        misalignTarget = '0;
        rngState = 32'd48573;
        genPc = pipeCtrlPkg::resetPc;
        lastRetirePc = '0;
        retireCount = 0;
        errCount = 0;
        checkTotal = 0;
        testsRun = 0;
        testsFailed = 0;
        curTest = "reset";
        resetDut();
        straightTest();
        randomWaitTest();
        branchTest();
        misalignTest();
        excpTest();
        fetchWaitBranchTest();
        $display("tests %0d, failed %0d, checks %0d, errors %0d, retires %0d",
                 testsRun, testsFailed, checkTotal, errCount, retireCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
